//--- hw/msx_mapper_cfg.svh
`ifndef MSX_MAPPER_CFG_SVH
`define MSX_MAPPER_CFG_SVH

`define MSX_ROM_AW      27
`define MSX_SRAM_AW     12
`define MSX_SRAM_BYTES  4096

// national bank registers, bank 0 sits above bank 1 in the map
`define NAT_BANK0_ADDR  16'h6400
`define NAT_BANK1_ADDR  16'h6000
`define NAT_BANK2_ADDR  16'h7000
`define NAT_BANK3_ADDR  16'h7400
`define NAT_CTRL_ADDR   16'h7FF9
`define NAT_PORT_HI     14'h3FFA
`define NAT_PORT_MID    14'h3FFB
`define NAT_PORT_LO     14'h3FFC
`define NAT_PORT_DATA   14'h3FFD
`define NAT_CTRL_SRAM   1       // control bit that opens the sram pointer ports
`define NAT_CTRL_RDBK   2       // control bit that enables bank readback

`define A8_BANK0_ADDR   16'h6000
`define A8_BANK1_ADDR   16'h6800
`define A8_BANK2_ADDR   16'h7000
`define A8_BANK3_ADDR   16'h7800

`endif

//--- hw/msx_mapper_pkg.sv
`default_nettype none

`include "msx_mapper_cfg.svh"

package msx_mapper_pkg;

    typedef enum logic [2:0] {
        MAPPER_NONE,
        MAPPER_NATIONAL,
        MAPPER_ASCII8
    } mapper_type_e;

    // one cpu bus cycle, req marks the first cycle of rd or wr
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        mreq;
        logic        req;
        logic        rd;
        logic        wr;
    } cpu_bus_req_t;

    typedef struct packed {
        mapper_type_e typ;
        logic         sram_en;
    } block_info_t;

    // a register read is answered with both selects low and addr parked at all ones
    typedef struct packed {
        logic                   ram_cs;
        logic                   sram_cs;
        logic                   rnw;
        logic [`MSX_ROM_AW-1:0] addr;
        logic [7:0]             data;
    } mapper_out_t;

    // output of a slot with no mapper selected
    localparam mapper_out_t MAPPER_OUT_IDLE = '{
        ram_cs:  1'b0,
        sram_cs: 1'b0,
        rnw:     1'b1,
        addr:    {`MSX_ROM_AW{1'b1}},
        data:    8'hFF
    };

endpackage

`default_nettype wire

//--- hw/mapper_national.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module mapper_national (
    input  wire logic                          cpu_bus,
    input  wire logic                          rst_n,
    input  wire msx_mapper_pkg::cpu_bus_req_t  cpu,
    input  wire msx_mapper_pkg::block_info_t   info,
    output msx_mapper_pkg::mapper_out_t        out
);

    import msx_mapper_pkg::*;

    logic [7:0]             bank [4];
    logic [7:0]             control;
    logic [23:0]            sram_ptr;
    logic [`MSX_SRAM_AW-1:0] sram_hold;     // pointer value latched at the port access
    logic                   sram_wr;
    logic                   sram_rd;
    logic                   cs;
    logic                   reg_wr;
    logic                   port_hit;
    logic                   port_acc;
    logic                   sram_rq;
    logic                   reg_win;
    logic                   bank_rd;
    logic [`MSX_ROM_AW-1:0] rom_addr;

    assign cs       = (info.typ == MAPPER_NATIONAL) && cpu.mreq;
    assign reg_wr   = cs && cpu.req && cpu.wr;
    assign port_hit = control[`NAT_CTRL_SRAM] && (cpu.addr[13:0] == `NAT_PORT_DATA);
    assign port_acc = cs && cpu.req && port_hit && (cpu.wr || cpu.rd);
    assign sram_rq  = cs && cpu.rd && port_hit;

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            bank     <= '{default: '0};
            control  <= '0;
            sram_ptr <= '0;
            sram_wr  <= 1'b0;
            sram_rd  <= 1'b0;
        end else begin
            // strobes drop as soon as the cpu releases its level
            if (!cpu.wr)
                sram_wr <= 1'b0;
            if (!cpu.rd)
                sram_rd <= 1'b0;

            if (reg_wr) begin
                case (cpu.addr)
                    `NAT_BANK0_ADDR: bank[0] <= cpu.data;
                    `NAT_BANK1_ADDR: bank[1] <= cpu.data;
                    `NAT_BANK2_ADDR: bank[2] <= cpu.data;
                    `NAT_BANK3_ADDR: bank[3] <= cpu.data;
                    `NAT_CTRL_ADDR:  control <= cpu.data;
                    default: begin
                        if (control[`NAT_CTRL_SRAM]) begin
                            case (cpu.addr[13:0])
                                `NAT_PORT_HI:  sram_ptr[23:16] <= cpu.data;
                                `NAT_PORT_MID: sram_ptr[15:8]  <= cpu.data;
                                `NAT_PORT_LO:  sram_ptr[7:0]   <= cpu.data;
                                default: ;
                            endcase
                        end
                    end
                endcase
            end

            if (port_acc) begin
                sram_ptr <= sram_ptr + 1'b1;
                if (cpu.wr)
                    sram_wr <= 1'b1;
                if (cpu.rd)
                    sram_rd <= 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (port_acc)
            sram_hold <= sram_ptr[`MSX_SRAM_AW-1:0];
    end

    // 7FF8..7FFF is the readback window, only even addresses return a bank
    assign reg_win  = cs && control[`NAT_CTRL_RDBK] && (cpu.addr[14:3] == 12'hFFF);
    assign bank_rd  = reg_win && !cpu.addr[0];
    assign rom_addr = {5'b0, bank[cpu.addr[15:14]], cpu.addr[13:0]};

    assign out.ram_cs  = cs && cpu.rd && !sram_rq && !reg_win;
    assign out.sram_cs = (sram_rd || sram_wr) && info.sram_en;
    assign out.rnw     = !sram_wr;
    assign out.data    = bank_rd ? bank[cpu.addr[2:1]] : 8'hFF;

    always_comb begin
        if (!cs || bank_rd)
            out.addr = {`MSX_ROM_AW{1'b1}};
        else if (sram_rq || sram_wr)
            out.addr = {{(`MSX_ROM_AW-`MSX_SRAM_AW){1'b0}}, sram_hold};
        else
            out.addr = rom_addr;
    end

endmodule

`default_nettype wire

//--- hw/mapper_ascii8.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module mapper_ascii8 (
    input  wire logic                          cpu_bus,
    input  wire logic                          rst_n,
    input  wire msx_mapper_pkg::cpu_bus_req_t  cpu,
    input  wire msx_mapper_pkg::block_info_t   info,
    output msx_mapper_pkg::mapper_out_t        out
);

    import msx_mapper_pkg::*;

    logic [7:0] bank [4];
    logic       cs;
    logic       rom_win;

    assign cs      = (info.typ == MAPPER_ASCII8) && cpu.mreq;
    assign rom_win = (cpu.addr[15:14] == 2'b01) || (cpu.addr[15:14] == 2'b10);   // 4000..BFFF

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            bank <= '{default: '0};
        end else if (cs && cpu.req && cpu.wr) begin
            case (cpu.addr)
                `A8_BANK0_ADDR: bank[0] <= cpu.data;
                `A8_BANK1_ADDR: bank[1] <= cpu.data;
                `A8_BANK2_ADDR: bank[2] <= cpu.data;
                `A8_BANK3_ADDR: bank[3] <= cpu.data;
                default: ;
            endcase
        end
    end

    assign out.ram_cs  = cs && cpu.rd && rom_win;
    assign out.sram_cs = 1'b0;
    assign out.rnw     = 1'b1;
    assign out.data    = 8'hFF;

    // upper bits stay zero so this never looks like a register read
    assign out.addr    = {6'b0, bank[cpu.addr[14:13]], cpu.addr[12:0]};

endmodule

`default_nettype wire

//--- hw/cart_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module cart_sram (
    input  wire logic                    cpu_bus,
    input  wire logic                    we,
    input  wire logic                    re,
    input  wire logic [`MSX_SRAM_AW-1:0] addr,
    input  wire logic [7:0]              wdata,
    output logic [7:0]                   rdata,
    output logic                         rvalid
);

    logic [7:0] mem [`MSX_SRAM_BYTES];
    logic       re_q;

    always_ff @(posedge cpu_bus) begin
        if (we)
            mem[addr] <= wdata;     // repeats while the strobe is held, same address and data
        if (re)
            rdata <= mem[addr];
    end

    // one valid pulse per read strobe, settles low once re has been low a cycle
    always_ff @(posedge cpu_bus) begin
        re_q   <= re;
        rvalid <= re && !re_q;
    end

endmodule

`default_nettype wire

//--- hw/slot_data_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module slot_data_path (
    input  wire msx_mapper_pkg::mapper_type_e  typ,
    input  wire msx_mapper_pkg::cpu_bus_req_t  cpu,
    input  wire msx_mapper_pkg::mapper_out_t   nat_out,
    input  wire msx_mapper_pkg::mapper_out_t   a8_out,
    input  wire logic [7:0]                    sram_rdata,
    input  wire logic                          sram_rvalid,
    output logic                               rom_cs,
    output logic [`MSX_ROM_AW-1:0]             rom_addr,
    output logic                               sram_we,
    output logic                               sram_re,
    output logic [`MSX_SRAM_AW-1:0]            sram_addr,
    output logic [7:0]                         sram_wdata,
    output logic [7:0]                         rd_data,
    output logic                               rd_valid
);

    import msx_mapper_pkg::*;

    mapper_out_t sel;
    logic        sel_hit;
    logic        reg_rd;

    always_comb begin
        sel     = MAPPER_OUT_IDLE;
        sel_hit = 1'b0;
        case (typ)
            MAPPER_NATIONAL: begin
                sel     = nat_out;
                sel_hit = 1'b1;
            end
            MAPPER_ASCII8: begin
                sel     = a8_out;
                sel_hit = 1'b1;
            end
            default: ;
        endcase
    end

    // a read the mapper answers itself, see mapper_out_t
    assign reg_rd = sel_hit && cpu.mreq && cpu.rd && !sel.ram_cs && !sel.sram_cs && (&sel.addr);

    assign rom_cs     = sel.ram_cs;
    assign rom_addr   = sel.addr;
    assign sram_we    = sel.sram_cs && !sel.rnw;
    assign sram_re    = sel.sram_cs && sel.rnw;
    assign sram_addr  = sel.addr[`MSX_SRAM_AW-1:0];
    assign sram_wdata = cpu.data;

    assign rd_data  = sram_rvalid ? sram_rdata : (reg_rd ? sel.data : 8'hFF);
    assign rd_valid = sram_rvalid || reg_rd;

endmodule

`default_nettype wire

//--- hw/msx_cart_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module msx_cart_top (
    input  wire logic                          cpu_bus,
    input  wire logic                          rst_n,
    input  wire msx_mapper_pkg::cpu_bus_req_t  cpu,
    input  wire msx_mapper_pkg::block_info_t   info,
    output logic                               rom_cs,
    output logic [`MSX_ROM_AW-1:0]             rom_addr,
    output logic [7:0]                         rd_data,
    output logic                               rd_valid
);

    import msx_mapper_pkg::*;

    mapper_out_t             nat_out;
    mapper_out_t             a8_out;
    logic                    sram_we;
    logic                    sram_re;
    logic [`MSX_SRAM_AW-1:0] sram_addr;
    logic [7:0]              sram_wdata;
    logic [7:0]              sram_rdata;
    logic                    sram_rvalid;

    mapper_national mapper_national_i (.cpu_bus, .rst_n, .cpu, .info, .out(nat_out));

    mapper_ascii8 mapper_ascii8_i (.cpu_bus, .rst_n, .cpu, .info, .out(a8_out));

    slot_data_path slot_data_path_i (
        .typ(info.typ), .cpu, .nat_out, .a8_out,
        .sram_rdata, .sram_rvalid,
        .rom_cs, .rom_addr,
        .sram_we, .sram_re, .sram_addr, .sram_wdata,
        .rd_data, .rd_valid
    );

    cart_sram cart_sram_i (
        .cpu_bus, .we(sram_we), .re(sram_re), .addr(sram_addr),
        .wdata(sram_wdata), .rdata(sram_rdata), .rvalid(sram_rvalid)
    );

endmodule

`default_nettype wire

//--- tb/tb_cart_model.svh
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// the model sees the same bus writes as the DUT and keeps its own copy of every register
logic [7:0]  nat_bank [4];
logic [7:0]  nat_ctrl;
logic [23:0] nat_ptr;
logic [7:0]  a8_bank [4];
logic [7:0]  sram_mem [`MSX_SRAM_BYTES];

task automatic clear_model();
    nat_bank = '{default: '0};
    a8_bank  = '{default: '0};
    nat_ctrl = '0;
    nat_ptr  = '0;
endtask

task automatic track_write(input block_info_t bi, input logic [15:0] a, input logic [7:0] d);
    if (bi.typ == MAPPER_ASCII8 && a[15:13] == 3'b011 && a[10:0] == '0)
        a8_bank[a[12:11]] = d;      // 6000, 6800, 7000 and 7800 in that order
    if (bi.typ == MAPPER_NATIONAL) begin
        case (a)
            `NAT_BANK0_ADDR: nat_bank[0] = d;
            `NAT_BANK1_ADDR: nat_bank[1] = d;
            `NAT_BANK2_ADDR: nat_bank[2] = d;
            `NAT_BANK3_ADDR: nat_bank[3] = d;
            `NAT_CTRL_ADDR:  nat_ctrl = d;
            default: begin
                if (nat_ctrl[`NAT_CTRL_SRAM]) begin
                    case (a[13:0])
                        `NAT_PORT_HI:  nat_ptr[23:16] = d;
                        `NAT_PORT_MID: nat_ptr[15:8] = d;
                        `NAT_PORT_LO:  nat_ptr[7:0] = d;
                        `NAT_PORT_DATA: begin
                            if (bi.sram_en)
                                sram_mem[nat_ptr[`MSX_SRAM_AW-1:0]] = d;
                            nat_ptr = nat_ptr + 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
        endcase
    end
endtask

// a data-port read returns the byte under the pointer and moves it on
task automatic take_sram_byte(output logic [7:0] d);
    d       = sram_mem[nat_ptr[`MSX_SRAM_AW-1:0]];
    nat_ptr = nat_ptr + 1'b1;
endtask

function automatic logic [`MSX_ROM_AW-1:0] nat_rom_addr(input logic [15:0] a);
    return (27'(nat_bank[a[15:14]]) << 14) | 27'(a[13:0]);
endfunction

function automatic logic [`MSX_ROM_AW-1:0] a8_rom_addr(input logic [15:0] a);
    return (27'(a8_bank[a[14:13]]) << 13) | 27'(a[12:0]);
endfunction

`endif

//--- tb/tb_msx_cart.sv
`timescale 1ns/10ps
`default_nettype none

`include "msx_mapper_cfg.svh"

module tb_msx_cart;

    import msx_mapper_pkg::*;

    localparam int N_BANK_WR = 12;
    localparam int RD_PER_WR = 3;
    localparam int N_ROM_RD  = 32;
    localparam int N_SRAM    = 10;
    // reset and the fixed steps take 43 cycles and the rest scales with the loop counts
    localparam int CYCLE_LIMIT = 43 + (2 + RD_PER_WR) * N_BANK_WR + 2 * N_ROM_RD + 7 * N_SRAM + 60;
    localparam logic [15:0] DATA_PORT = {2'b00, `NAT_PORT_DATA};

    logic                   cpu_bus;
    logic                   rst_n;
    cpu_bus_req_t           cpu;
    block_info_t            info;
    logic                   rom_cs;
    logic [`MSX_ROM_AW-1:0] rom_addr;
    logic [7:0]             rd_data;
    logic                   rd_valid;
    logic [31:0]            lcg_state;
    logic [15:0]            nat_addrs [4] = '{`NAT_BANK0_ADDR, `NAT_BANK1_ADDR,
                                              `NAT_BANK2_ADDR, `NAT_BANK3_ADDR};
    int                     cycle_cnt = 0;
    int                     test_errs = 0;
    int                     total_errs = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    `include "tb_cart_model.svh"

    msx_cart_top msx_cart_top_i (
        .cpu_bus, .rst_n, .cpu, .info, .rom_cs, .rom_addr, .rd_data, .rd_valid
    );

    initial begin
        cpu_bus = 1'b0;
        forever #10 cpu_bus = ~cpu_bus;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge cpu_bus);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic expect_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        tests_failed += (test_errs != 0);
        total_errs   += test_errs;
        $display("test %0d %s: %0d errors", tests_run, name, test_errs);
        test_errs = 0;
    endtask

    // new bus values go out on the falling edge and outputs are read 5 ns later
    task automatic drive(input cpu_bus_req_t v);
        @(negedge cpu_bus);
        cpu = v;
        #5;
    endtask

    task automatic set_info(input mapper_type_e t, input logic en);
        @(negedge cpu_bus);
        info = '{typ: t, sram_en: en};
        cpu  = '0;
        #5;
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        drive('{addr: a, data: d, mreq: 1'b1, req: 1'b1, rd: 1'b0, wr: 1'b1});
        drive('0);
        track_write(info, a, d);
    endtask

    task automatic load_ptr(input logic [23:0] p);
        write_reg({2'b00, `NAT_PORT_HI}, p[23:16]);
        write_reg({2'b00, `NAT_PORT_MID}, p[15:8]);
        write_reg({2'b00, `NAT_PORT_LO}, p[7:0]);
    endtask

    task automatic write_port(input logic [7:0] d);
        drive('{addr: DATA_PORT, data: d, mreq: 1'b1, req: 1'b1, rd: 1'b0, wr: 1'b1});
        drive('{addr: DATA_PORT, data: d, mreq: 1'b1, req: 1'b0, rd: 1'b0, wr: 1'b1});
        // mreq stays up until the write strobe has dropped
        drive('{addr: DATA_PORT, data: d, mreq: 1'b1, req: 1'b0, rd: 1'b0, wr: 1'b0});
        track_write(info, DATA_PORT, d);
    endtask

    task automatic read_port(output logic [7:0] got, output int pulses);
        got    = 8'hFF;
        pulses = 0;
        for (int c = 0; c < 4; c++) begin
            // rd is held for three cycles and the fourth releases the bus
            drive('{addr: DATA_PORT, data: 8'h00, mreq: c < 3, req: c == 0, rd: c < 3, wr: 1'b0});
            if (rd_valid) begin
                got = rd_data;
                pulses++;
            end
        end
    endtask

    task automatic check_rom_read(input logic [15:0] a);
        logic [`MSX_ROM_AW-1:0] exp;
        if (info.typ == MAPPER_NATIONAL)
            exp = nat_rom_addr(a);
        else if (info.typ == MAPPER_ASCII8)
            exp = a8_rom_addr(a);
        else
            exp = '1;
        drive('{addr: a, data: 8'h00, mreq: 1'b1, req: 1'b1, rd: 1'b1, wr: 1'b0});
        expect_val(rom_cs, info.typ != MAPPER_NONE, "rom_cs");
        expect_val(rom_addr, exp, "rom_addr");
        expect_val(rd_data, 8'hFF, "rd_data");
        expect_val(rd_valid, 1'b0, "rd_valid");
    endtask

    initial begin
        logic [31:0] r;
        logic [23:0] p;
        logic [15:0] a;
        logic [7:0]  got;
        logic [7:0]  want;
        int          pulses;
        lcg_state = 32'h401a722c;
        cpu       = '0;
        info      = '{typ: MAPPER_NATIONAL, sram_en: 1'b0};
        rst_n     = 1'b0;
        clear_model();
        repeat (2) @(negedge cpu_bus);
        rst_n = 1'b1;

        drive('0);
        expect_val(rom_cs, 1'b0, "rom_cs with no request");
        check_rom_read(16'h8000);    // bank 2 is still zero
        end_test("reset state");

        for (int i = 0; i < N_BANK_WR; i++) begin
            r = lcg_next();
            write_reg(nat_addrs[r[9:8]], r[23:16]);
            repeat (RD_PER_WR) begin
                r = lcg_next();
                check_rom_read(r[31:16]);
            end
        end
        end_test("national banking");

        write_reg(`NAT_CTRL_ADDR, 8'(1 << `NAT_CTRL_RDBK));
        for (int k = 0; k < 8; k++) begin
            a = 16'h7FF8 + 16'(k);
            drive('{addr: a, data: 8'h00, mreq: 1'b1, req: 1'b1, rd: 1'b1, wr: 1'b0});
            expect_val(rd_valid, !a[0], "readback rd_valid");
            expect_val(rd_data, a[0] ? 8'hFF : nat_bank[a[2:1]], "readback rd_data");
            expect_val(rom_cs, 1'b0, "readback rom_cs");
        end
        end_test("national readback");

        set_info(MAPPER_NATIONAL, 1'b1);
        write_reg(`NAT_CTRL_ADDR, 8'(1 << `NAT_CTRL_SRAM));
        r = lcg_next();
        p = r[31:8];
        load_ptr(p);
        repeat (N_SRAM) begin
            r = lcg_next();
            write_port(r[23:16]);
        end
        load_ptr(p);
        repeat (N_SRAM) begin
            read_port(got, pulses);
            take_sram_byte(want);
            expect_val(pulses, 1, "sram rd_valid pulses");
            expect_val(got, want, "sram read data");
        end
        end_test("sram pointer");

        // sram_en stays set so a national data-port access would show up here
        set_info(MAPPER_ASCII8, 1'b1);
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            write_reg(16'h6000 + 16'(i << 11), r[23:16]);
        end
        repeat (N_ROM_RD) begin
            r = lcg_next();
            check_rom_read(16'h4000 + 16'(r[30:16]));
        end
        read_port(got, pulses);
        expect_val(pulses, 0, "ascii8 data port rd_valid pulses");
        end_test("ascii8 banking");

        set_info(MAPPER_NONE, 1'b0);
        repeat (N_ROM_RD) begin
            r = lcg_next();
            check_rom_read(r[31:16]);
        end
        end_test("no mapper");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- msx_mapper.f
+incdir+hw
+incdir+tb
hw/msx_mapper_pkg.sv
hw/mapper_national.sv
hw/mapper_ascii8.sv
hw/cart_sram.sv
hw/slot_data_path.sv
hw/msx_cart_top.sv
tb/tb_msx_cart.sv
